/* logic/elevator_config.svh */
// Elevator request controller constants
// Floor count, request queue depth and the widths derived from them

`ifndef ELEVATOR_CONFIG_SVH
`define ELEVATOR_CONFIG_SVH

// Car serves floors 1 through 11
`define FLOOR_COUNT   11
`define FLOOR_WIDTH   4

// Request queue size and a credit counter able to hold 0 to REQUEST_DEPTH
`define REQUEST_DEPTH 8
`define CREDIT_WIDTH  4

`endif

/* logic/elevator_pkg.sv */
// Elevator request types
// Floor numbers, button masks, request records and dispatcher encodings

`include "elevator_config.svh"

package elevator_pkg;

    // Floor 1 is encoded as 0, floor 11 as 10
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, for buttons and lamps
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    // A queued request, or a floor that has just been served
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_request_t;

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

    typedef enum logic {
        DISPATCH_IDLE   = 1'b0,
        DISPATCH_TRAVEL = 1'b1
    } dispatch_state_t;

endpackage

/* logic/button_latch.sv */
// Button latch for panel and hall calls
// Lights lamps, pushes one request per cycle under credit control

`timescale 1ns/1ps
`include "elevator_config.svh"

module button_latch
    import elevator_pkg::*;
(
    input  logic           clock,
    input  logic           reset_n,
    input  floor_mask_t    floor_call_buttons,
    input  floor_mask_t    panel_buttons,
    input  logic           power_switch,
    input  logic           emergency_btn,
    input  floor_t         current_floor,
    input  floor_request_t served,
    input  logic           credit_return,
    output floor_request_t push,
    output floor_mask_t    call_button_lights,
    output floor_mask_t    panel_button_lights
);

    logic [`CREDIT_WIDTH-1:0] credits;
    floor_mask_t              current_mask;
    floor_mask_t              served_mask;
    floor_mask_t              lit_mask;
    floor_mask_t              panel_ready;
    floor_mask_t              call_ready;
    floor_mask_t              pick_mask;
    floor_t                   pick_floor;
    logic                     accept_enable;
    logic                     take_panel;
    logic                     take_call;
    logic                     push_now;

    //////////////////////////////////////////////////
    // Request selection
    //////////////////////////////////////////////////

    assign current_mask  = floor_mask_t'(1) << current_floor;
    assign served_mask   = served.valid ? (floor_mask_t'(1) << served.floor) : '0;
    assign accept_enable = power_switch && !emergency_btn && (credits != '0);

    // A floor is requested once, whichever button lit it
    assign lit_mask = panel_button_lights | call_button_lights;

    // A button only counts while its floor is dark and the car is elsewhere
    assign panel_ready = panel_buttons & ~lit_mask & ~current_mask;
    assign call_ready  = floor_call_buttons & ~lit_mask & ~current_mask;

    // Panel presses win over hall calls
    assign take_panel = accept_enable && (panel_ready != '0);
    assign take_call  = accept_enable && !take_panel && (call_ready != '0);
    assign push_now   = take_panel || take_call;

    // Lowest floor index wins within the chosen source
    always_comb begin
        floor_mask_t source;
        source = take_panel ? panel_ready : call_ready;
        pick_floor = '0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (source[i]) begin
                pick_floor = floor_t'(i);
            end
        end
    end

    assign pick_mask = floor_mask_t'(1) << pick_floor;

    //////////////////////////////////////////////////
    // Lamps, push and credits
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
            push                <= '0;
        end else begin
            panel_button_lights <= (panel_button_lights & ~served_mask) |
                                   (take_panel ? pick_mask : '0);
            call_button_lights  <= (call_button_lights & ~served_mask) |
                                   (take_call ? pick_mask : '0);
            push.valid          <= push_now;
            push.floor          <= pick_floor;
        end
    end

    // One credit per free queue entry
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            credits <= `CREDIT_WIDTH'(`REQUEST_DEPTH);
        end else begin
            case ({push_now, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* logic/request_fifo.sv */
// Request queue
// Circular buffer of floor requests, hands back a credit for each freed entry

`timescale 1ns/1ps
`include "elevator_config.svh"

module request_fifo
    import elevator_pkg::*;
(
    input  logic           clock,
    input  logic           reset_n,
    input  floor_request_t push,
    input  logic           pop,
    output floor_request_t head,
    output logic           credit_return
);

    localparam int PTR_WIDTH = $clog2(`REQUEST_DEPTH);

    floor_t                   mem [`REQUEST_DEPTH];
    logic [PTR_WIDTH-1:0]     wr_ptr;
    logic [PTR_WIDTH-1:0]     rd_ptr;
    logic [`CREDIT_WIDTH-1:0] count;
    logic                     write_en;
    logic                     read_en;

    // Pointer advance with wrap at the last entry
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(`REQUEST_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign write_en = push.valid && (count != `CREDIT_WIDTH'(`REQUEST_DEPTH));
    assign read_en  = pop && (count != '0);

    assign head.valid = (count != '0);
    assign head.floor = mem[rd_ptr];

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[wr_ptr] <= push.floor;
        end
    end

    //////////////////////////////////////////////////
    // Pointers, occupancy and credit return
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (write_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (read_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({write_en, read_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Freed entry goes back to the latch one cycle after the pop
            credit_return <= read_en;
        end
    end

endmodule

/* logic/floor_dispatcher.sv */
// Floor dispatcher
// Sends the car to the oldest request, reports served floors, grants door control

`timescale 1ns/1ps

module floor_dispatcher
    import elevator_pkg::*;
(
    input  logic           clock,
    input  logic           reset_n,
    input  floor_request_t head,
    input  floor_t         current_floor,
    input  logic           elevator_moving,
    input  logic           power_switch,
    input  logic           emergency_btn,
    input  logic           door_open_btn,
    input  logic           door_close_btn,
    output logic           pop,
    output floor_request_t served,
    output floor_t         elevator_floor_selector,
    output direction_t     direction_selector,
    output logic           activate_elevator,
    output logic           door_open_allowed,
    output logic           door_close_allowed
);

    dispatch_state_t state;
    direction_t      head_dir;
    direction_t      travel_dir;
    logic            arrived;

    //////////////////////////////////////////////////
    // Car commands
    //////////////////////////////////////////////////

    assign head_dir = (head.floor > current_floor) ? DIR_UP : DIR_DOWN;

    assign activate_elevator = power_switch && !emergency_btn && head.valid &&
                               !elevator_moving && (head.floor != current_floor);

    assign elevator_floor_selector = head.floor;

    // Hold the departure direction for the whole trip
    assign direction_selector = (state == DISPATCH_TRAVEL) ? travel_dir : head_dir;

    // Car standing at the head floor; a pop in flight blocks a second one
    assign arrived = head.valid && !elevator_moving &&
                     (head.floor == current_floor) && !pop;

    //////////////////////////////////////////////////
    // Dispatch FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= DISPATCH_IDLE;
            travel_dir <= DIR_DOWN;
            pop        <= 1'b0;
            served     <= '0;
        end else begin
            case (state)
                DISPATCH_IDLE: begin
                    if (activate_elevator) begin
                        state      <= DISPATCH_TRAVEL;
                        travel_dir <= head_dir;
                    end
                end
                DISPATCH_TRAVEL: begin
                    if (arrived) begin
                        state <= DISPATCH_IDLE;
                    end
                end
                default: state <= DISPATCH_IDLE;
            endcase
            pop          <= arrived;
            served.valid <= arrived;
            served.floor <= head.floor;
        end
    end

    // Doors only answer while stopped with power on
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_btn && !elevator_moving && power_switch;
            door_close_allowed <= door_close_btn && !elevator_moving && power_switch;
        end
    end

endmodule

/* logic/elevator_requests_top.sv */
// Elevator request controller top level
// Button latch feeds the request queue, which the dispatcher drains

`timescale 1ns/1ps

module elevator_requests_top
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,
    input  floor_t      current_floor,
    input  logic        elevator_moving,
    output floor_t      elevator_floor_selector,
    output direction_t  direction_selector,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed,
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights
);

    floor_request_t push;
    floor_request_t head;
    floor_request_t served;
    logic           credit_return;
    logic           pop;

    button_latch button_latch0 (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .current_floor       (current_floor),
        .served              (served),
        .credit_return       (credit_return),
        .push                (push),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    request_fifo request_fifo0 (
        .clock         (clock),
        .reset_n       (reset_n),
        .push          (push),
        .pop           (pop),
        .head          (head),
        .credit_return (credit_return)
    );

    floor_dispatcher floor_dispatcher0 (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .head                    (head),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .pop                     (pop),
        .served                  (served),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

/* test/elevator_requests_tb.sv */
// Elevator request controller testbench
// Car model, directed and random presses, assertion checks and a run watchdog

`timescale 1ns/1ps
`include "elevator_config.svh"

module elevator_requests_tb
    import elevator_pkg::*;
;

    localparam int CLOCK_PERIOD = 20;
    localparam int TEST_COUNT   = 6;
    localparam int TEST_CYCLES  = 1000;
    localparam int WAIT_LIMIT   = 900;
    localparam int WATCHDOG_CYCLES = 8 + TEST_COUNT * TEST_CYCLES + 200;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        elevator_moving;
    floor_t      elevator_floor_selector;
    direction_t  direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;

    int          error_count = 0;
    string       test_name = "reset";
    logic        hold_moving = 1'b0;
    int          order_q[$];

    elevator_requests_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic int lamps_lit();
        return $countones(panel_button_lights | call_button_lights);
    endfunction

    //////////////////////////////////////////////////
    // Car model, one floor per 4 cycles
    //////////////////////////////////////////////////

    initial begin
        logic   go_request;
        logic   hold_request;
        floor_t go_target;
        floor_t car_target;
        logic   traveling;
        int     step;
        current_floor   = '0;
        elevator_moving = 1'b0;
        traveling       = 1'b0;
        car_target      = '0;
        step            = 0;
        forever begin
            @(negedge clock);
            go_request   = activate_elevator;
            go_target    = elevator_floor_selector;
            hold_request = hold_moving;
            @(posedge clock);
            #2;
            if (!reset_n) begin
                traveling       = 1'b0;
                elevator_moving = 1'b0;
            end else if (hold_request) begin
                elevator_moving = 1'b1;
            end else if (traveling) begin
                step++;
                if (step == 4) begin
                    step = 0;
                    current_floor = (car_target > current_floor) ? current_floor + 1'b1
                                                                 : current_floor - 1'b1;
                    traveling = (current_floor != car_target);
                end
                elevator_moving = traveling;
            end else if (go_request) begin
                car_target      = go_target;
                traveling       = 1'b1;
                step            = 0;
                elevator_moving = 1'b1;
            end else begin
                elevator_moving = 1'b0;
            end
        end
    end

    // Lamps must go dark in the order they lit
    always @(negedge clock) begin
        floor_mask_t lit;
        floor_mask_t prev_lit;
        lit = panel_button_lights | call_button_lights;
        if (!reset_n) begin
            order_q.delete();
        end else begin
            for (int i = 0; i < `FLOOR_COUNT; i++) begin
                if (prev_lit[i] && !lit[i]) begin
                    if (order_q.size() == 0) begin
                        error_count++;
                        $display("lamp %0d went dark with no request outstanding", i);
                    end else begin
                        assert (order_q[0] == i) else begin
                            error_count++;
                            $display("error %s: expected served floor %0d, actual %0d",
                                     test_name, order_q[0], i);
                        end
                        void'(order_q.pop_front());
                    end
                end
            end
            for (int i = 0; i < `FLOOR_COUNT; i++) begin
                if (lit[i] && !prev_lit[i]) begin
                    order_q.push_back(i);
                end
            end
        end
        prev_lit = lit;
    end

    //////////////////////////////////////////////////
    // Concurrent checks
    //////////////////////////////////////////////////

    for (genvar g = 0; g < `FLOOR_COUNT; g++) begin : g_lamp
        assert property (@(posedge clock) disable iff (!reset_n)
            $rose(panel_button_lights[g]) |-> $past(panel_buttons[g] && power_switch &&
                !emergency_btn && current_floor != floor_t'(g)))
        else begin
            error_count++;
            $display("panel lamp %0d lit without an accepted press in %s", g, test_name);
        end
        assert property (@(posedge clock) disable iff (!reset_n)
            $rose(call_button_lights[g]) |-> $past(floor_call_buttons[g] && power_switch &&
                !emergency_btn && current_floor != floor_t'(g)))
        else begin
            error_count++;
            $display("call lamp %0d lit without an accepted press in %s", g, test_name);
        end
        // The car is standing at a floor when its lamps clear
        assert property (@(posedge clock) disable iff (!reset_n)
            $fell(panel_button_lights[g] | call_button_lights[g]) |->
                current_floor == floor_t'(g))
        else begin
            error_count++;
            $display("error %s: expected car at floor %0d, actual %0d",
                     test_name, g, current_floor);
        end
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        $countones(panel_button_lights | call_button_lights) <= `REQUEST_DEPTH)
    else begin
        error_count++;
        $display("more lamps lit than queue entries in %s", test_name);
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        (!power_switch || emergency_btn) |-> !activate_elevator)
    else begin
        error_count++;
        $display("car activated with power off or emergency in %s", test_name);
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        activate_elevator |-> (panel_button_lights[elevator_floor_selector] ||
            call_button_lights[elevator_floor_selector]))
    else begin
        error_count++;
        $display("car sent to floor %0d whose lamp is dark in %s",
                 elevator_floor_selector, test_name);
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        activate_elevator |-> direction_selector ==
            ((elevator_floor_selector > current_floor) ? DIR_UP : DIR_DOWN))
    else begin
        error_count++;
        $display("error %s: expected direction %0d, actual %0d", test_name,
                 ($sampled(elevator_floor_selector) > $sampled(current_floor)) ? DIR_UP
                                                                             : DIR_DOWN,
                 $sampled(direction_selector));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        door_open_allowed == $past(door_open_btn && !elevator_moving && power_switch))
    else begin
        error_count++;
        $display("error %s: expected door open grant %0b, actual %0b", test_name,
                 !$sampled(door_open_allowed), $sampled(door_open_allowed));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        door_close_allowed == $past(door_close_btn && !elevator_moving && power_switch))
    else begin
        error_count++;
        $display("error %s: expected door close grant %0b, actual %0b", test_name,
                 !$sampled(door_close_allowed), $sampled(door_close_allowed));
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    task automatic next_cycle(input int n = 1);
        repeat (n) @(posedge clock);
        #2;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            error_count++;
            $display("error %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // One-cycle press, lamp checked on the following cycle
    task automatic press_floor(input logic panel, input int floor, input int expect_lit);
        if (panel) panel_buttons[floor] = 1'b1;
        else floor_call_buttons[floor] = 1'b1;
        next_cycle();
        panel_buttons      = '0;
        floor_call_buttons = '0;
        check_value($sformatf("lamp %0d", floor), expect_lit,
                    panel ? panel_button_lights[floor] : call_button_lights[floor]);
    endtask

    task automatic drain_requests();
        int cycles;
        cycles = 0;
        while ((lamps_lit() != 0 || elevator_moving) && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (cycles == WAIT_LIMIT) begin
            error_count++;
            $display("requests were not all served in %s", test_name);
        end
    endtask

    task automatic finish_test(input int start_errors);
        $display("test %s done, %0d errors", test_name, error_count - start_errors);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    initial begin
        int start_errors;
        int floors[$];
        int cycles;
        int first;
        int pick;
        int spare;
        void'($urandom(30));
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        next_cycle(8);
        reset_n = 1'b1;
        next_cycle(2);

        test_name = "dispatch_up";
        start_errors = error_count;
        press_floor(1'b1, 5, 1);
        cycles = 0;
        while (!activate_elevator && cycles < 20) begin
            next_cycle();
            cycles++;
        end
        check_value("activate", 1, activate_elevator);
        check_value("direction", DIR_UP, direction_selector);
        check_value("target floor", 5, elevator_floor_selector);
        drain_requests();
        finish_test(start_errors);

        test_name = "press_order";
        start_errors = error_count;
        floors = '{1, 3, 8, 10, 6};
        // Random press order
        for (int i = floors.size() - 1; i > 0; i--) begin
            pick = $urandom_range(i, 0);
            spare = floors[i];
            floors[i] = floors[pick];
            floors[pick] = spare;
        end
        foreach (floors[i]) begin
            if (floors[i] != current_floor) begin
                press_floor($urandom_range(1, 0), floors[i], 1);
            end
        end
        drain_requests();
        finish_test(start_errors);

        test_name = "ignored_press";
        start_errors = error_count;
        hold_moving = 1'b1;
        next_cycle();
        press_floor(1'b1, current_floor, 0);
        press_floor(1'b0, current_floor, 0);
        first = (current_floor == 2) ? 7 : 2;
        press_floor(1'b0, first, 1);
        press_floor(1'b0, first, 1);
        press_floor(1'b1, first, 0);
        check_value("lamps lit", 1, lamps_lit());
        hold_moving = 1'b0;
        drain_requests();
        finish_test(start_errors);

        test_name = "queue_full";
        start_errors = error_count;
        hold_moving = 1'b1;
        next_cycle();
        panel_buttons = ~(floor_mask_t'(1) << current_floor);
        next_cycle(15);
        check_value("lamps lit", `REQUEST_DEPTH, lamps_lit());
        first = (current_floor == 0) ? 1 : 0;
        hold_moving = 1'b0;
        cycles = 0;
        while (panel_button_lights[first] && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        while (lamps_lit() < `REQUEST_DEPTH && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        panel_buttons = '0;
        check_value("lamps lit after one served", `REQUEST_DEPTH, lamps_lit());
        drain_requests();
        finish_test(start_errors);

        test_name = "power_emergency";
        start_errors = error_count;
        first = (current_floor == 4) ? 9 : 4;
        power_switch = 1'b0;
        press_floor(1'b1, first, 0);
        next_cycle(4);
        power_switch  = 1'b1;
        emergency_btn = 1'b1;
        press_floor(1'b0, first, 0);
        next_cycle(4);
        emergency_btn = 1'b0;
        check_value("lamps lit", 0, lamps_lit());
        // A request queued just before the switch goes off has to wait
        press_floor(1'b1, first, 1);
        power_switch = 1'b0;
        next_cycle(6);
        check_value("activate without power", 0, activate_elevator);
        power_switch  = 1'b1;
        emergency_btn = 1'b1;
        next_cycle(6);
        check_value("activate in emergency", 0, activate_elevator);
        check_value("car moving", 0, elevator_moving);
        emergency_btn = 1'b0;
        drain_requests();
        finish_test(start_errors);

        test_name = "door_grants";
        start_errors = error_count;
        door_open_btn = 1'b1;
        next_cycle();
        check_value("door open grant", 1, door_open_allowed);
        door_open_btn  = 1'b0;
        door_close_btn = 1'b1;
        next_cycle();
        check_value("door close grant", 1, door_close_allowed);
        hold_moving = 1'b1;
        next_cycle(2);
        check_value("door close grant while moving", 0, door_close_allowed);
        door_close_btn = 1'b0;
        power_switch   = 1'b0;
        hold_moving    = 1'b0;
        door_open_btn  = 1'b1;
        next_cycle(2);
        check_value("door open grant without power", 0, door_open_allowed);
        door_open_btn = 1'b0;
        power_switch  = 1'b1;
        next_cycle(2);
        finish_test(start_errors);

        $display("tests %0d, errors %0d", TEST_COUNT, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Run limit from the per-test budgets
    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* elevator_requests.f */
+incdir+logic
logic/elevator_pkg.sv
logic/button_latch.sv
logic/request_fifo.sv
logic/floor_dispatcher.sv
logic/elevator_requests_top.sv
test/elevator_requests_tb.sv

/* Makefile */
# Verilator build and run of the elevator request controller testbench

VERILATOR ?= verilator
TOP       ?= elevator_requests_tb
FILE_LIST ?= elevator_requests.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST))) logic/elevator_config.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
